//--- verilog/exePkg.sv
`default_nettype none

package exePkg;

    // ALU function codes from decode
    typedef enum logic [3:0]
    {
        aluAdd  = 4'd0,
        aluSub  = 4'd1,
        aluSll  = 4'd2,
        aluSlt  = 4'd3,
        aluSltu = 4'd4,
        aluXor  = 4'd5,
        aluSrl  = 4'd6,
        aluSra  = 4'd7,
        aluOr   = 4'd8,
        aluAnd  = 4'd9
    } aluOpT;

    typedef enum logic [3:0]
    {
        memNone = 4'd0,
        memLb   = 4'd1,
        memLh   = 4'd2,
        memLw   = 4'd3,
        memLbu  = 4'd4,
        memLhu  = 4'd5,
        memSb   = 4'd6,
        memSh   = 4'd7,
        memSw   = 4'd8
    } memOpT;

    // one instruction from the issue stage, operands already read
    typedef struct packed
    {
        logic        valid;
        logic        we;
        logic [4:0]  rd;
        aluOpT       aluOp;
        logic        btype;
        logic        bneq;      // invert branch condition
        logic        j;
        logic        jr;
        memOpT       memOp;
        logic [31:0] opA;
        logic [31:0] opB;       // I imm or store data
        logic [31:0] pc;
        logic [31:0] bImm;
        logic [31:0] jImm;
        logic [31:0] sImm;
    } issueBundleT;

    // pipe 5 result
    typedef struct packed
    {
        logic        valid;
        logic        we;
        logic [4:0]  rd;
        logic [31:0] aluRes;
        logic        redirect;
        logic [31:0] target;
    } exeResultT;

    // pipe 6 memory result
    typedef struct packed
    {
        logic        valid;
        logic [31:0] data;
        logic        addrMisaligned;
    } memResultT;

endpackage

`default_nettype wire

//--- verilog/exeAlu.sv
`timescale 1ns/1ns
`default_nettype none

module exeAlu
(
    input  exePkg::aluOpT aluOp,
    input  logic [31:0]   opA,
    input  logic [31:0]   opB,
    input  logic          btype,
    input  logic          bneq,
    output logic [31:0]   result,
    output logic          btaken
);
    import exePkg::*;

    logic [4:0] shamt;
    logic       condBit;   // raw compare outcome before bneq

    assign shamt = opB[4:0];

    always_comb
    begin
        result  = '0;
        condBit = 1'b0;
        case (aluOp)
            aluAdd:  result = opA + opB;
            aluSub:  result = opA - opB;
            aluSll:  result = opA << shamt;
            aluSlt:  result = {31'd0, $signed(opA) < $signed(opB)};
            aluSltu: result = {31'd0, opA < opB};
            aluXor:  result = opA ^ opB;
            aluSrl:  result = opA >> shamt;
            aluSra:  result = $unsigned($signed(opA) >>> shamt);
            aluOr:   result = opA | opB;
            aluAnd:  result = opA & opB;
            default: result = '0;
        endcase

        // beq/bne use sub, the rest use the set-less-than ops
        if (aluOp == aluSub)
        begin
            condBit = (result == 32'd0);
        end
        else if ((aluOp == aluSlt) || (aluOp == aluSltu))
        begin
            condBit = result[0];
        end
    end

    // bge/bgeu/bne come out as the inverted condition
    assign btaken = btype & (condBit ^ bneq);

endmodule

`default_nettype wire

//--- verilog/branchUnit.sv
`timescale 1ns/1ns
`default_nettype none

module branchUnit
(
    input  logic [31:0] pc,
    input  logic [31:0] opA,
    input  logic [31:0] opB,
    input  logic [31:0] bImm,
    input  logic [31:0] jImm,
    input  logic        j,
    input  logic        jr,
    input  logic        btaken,
    output logic [31:0] target,
    output logic        redirect
);

    logic [31:0] jrSum;

    assign jrSum = opA + opB;   // jalr base plus I imm

    always_comb
    begin
        if (jr)
        begin
            target = {jrSum[31:1], 1'b0};
        end
        else if (j)
        begin
            target = pc + jImm;
        end
        else if (btaken)
        begin
            target = pc + bImm;
        end
        else
        begin
            target = pc + 32'd4;   // fall through
        end
    end

    assign redirect = j | jr | btaken;

endmodule

`default_nettype wire

//--- verilog/dataMemWrap.sv
`timescale 1ns/1ns
`default_nettype none

module dataMemWrap #(parameter int MemWords = 256)
(
    input  logic              clk,
    input  logic              nrst,
    input  logic              valid,
    input  exePkg::memOpT     memOp,
    input  logic [31:0]       opA,
    input  logic [31:0]       opB,
    input  logic [31:0]       sImm,
    output exePkg::memResultT memOut
);
    import exePkg::*;

    // depth is a power of two, so slicing the index wraps the address
    localparam int IdxW = $clog2(MemWords);

    logic [31:0]     mem [MemWords];
    logic            isStore;
    logic [31:0]     addr;
    logic            reqValid;
    memOpT           reqOp;
    logic [31:0]     reqAddr;
    logic [31:0]     reqData;
    logic [IdxW-1:0] wordIdx;
    logic            misaligned;
    logic [3:0]      byteEn;
    logic [31:0]     wrData;
    logic [31:0]     rdWord;
    logic [31:0]     shifted;
    logic [31:0]     loadData;
    logic            outValid;
    logic            outMisaligned;
    logic [31:0]     outData;

    assign isStore = (memOp == memSb) || (memOp == memSh) || (memOp == memSw);
    assign addr    = opA + (isStore ? sImm : opB);

    // first step: capture the request
    always_ff @(posedge clk, negedge nrst)
    begin
        if (!nrst)
            reqValid <= 1'b0;
        else
            reqValid <= valid && (memOp != memNone);
    end

    always_ff @(posedge clk)
    begin
        reqOp   <= memOp;
        reqAddr <= addr;
        reqData <= opB;   // store data
    end

    assign wordIdx = reqAddr[IdxW+1:2];
    assign rdWord  = mem[wordIdx];
    assign shifted = rdWord >> {reqAddr[1:0], 3'b000};

    always_comb
    begin
        case (reqOp)
            memLh, memLhu, memSh: misaligned = reqAddr[0];
            memLw, memSw:         misaligned = |reqAddr[1:0];
            default:              misaligned = 1'b0;
        endcase
    end

    // byte lanes for stores
    always_comb
    begin
        byteEn = 4'b0000;
        wrData = reqData;
        case (reqOp)
            memSb:
            begin
                byteEn = 4'b0001 << reqAddr[1:0];
                wrData = {4{reqData[7:0]}};
            end
            memSh:
            begin
                byteEn = reqAddr[1] ? 4'b1100 : 4'b0011;
                wrData = {2{reqData[15:0]}};
            end
            memSw:   byteEn = 4'b1111;
            default: byteEn = 4'b0000;
        endcase
    end

    always_comb
    begin
        case (reqOp)
            memLb:   loadData = {{24{shifted[7]}}, shifted[7:0]};
            memLbu:  loadData = {24'd0, shifted[7:0]};
            memLh:   loadData = {{16{shifted[15]}}, shifted[15:0]};
            memLhu:  loadData = {16'd0, shifted[15:0]};
            memLw:   loadData = rdWord;
            default: loadData = '0;
        endcase
        if (misaligned)
            loadData = '0;
    end

    // second step: write or read
    always_ff @(posedge clk)
    begin
        if (reqValid && !misaligned)
        begin
            for (int i = 0; i < 4; i++)
            begin
                if (byteEn[i])
                    mem[wordIdx][8*i +: 8] <= wrData[8*i +: 8];
            end
        end
        outData <= loadData;
    end

    always_ff @(posedge clk, negedge nrst)
    begin
        if (!nrst)
        begin
            outValid      <= 1'b0;
            outMisaligned <= 1'b0;
        end
        else
        begin
            outValid      <= reqValid;
            outMisaligned <= reqValid && misaligned;
        end
    end

    assign memOut = memResultT'{valid: outValid, data: outData, addrMisaligned: outMisaligned};

endmodule

`default_nettype wire

//--- verilog/exeStage.sv
`timescale 1ns/1ns
`default_nettype none

module exeStage #(parameter int MemWords = 256)
(
    input  logic              clk,
    input  logic              nrst,
    input  exePkg::issueBundleT issue,
    output exePkg::exeResultT exeOut,
    output exePkg::memResultT memOut
);
    import exePkg::*;

    issueBundleT pipe5Reg;   // instruction in execute
    logic [31:0] aluRes;
    logic        btaken;
    logic [31:0] target;
    logic        redirect;

    // pipe 5 register
    always_ff @(posedge clk, negedge nrst)
    begin
        if (!nrst)
        begin
            pipe5Reg.valid <= 1'b0;
            pipe5Reg.we    <= 1'b0;
        end
        else
        begin
            pipe5Reg <= issue;
        end
    end

    exeAlu exeAlu0
    (
        .aluOp  (pipe5Reg.aluOp),
        .opA    (pipe5Reg.opA),
        .opB    (pipe5Reg.opB),
        .btype  (pipe5Reg.btype),
        .bneq   (pipe5Reg.bneq),
        .result (aluRes),
        .btaken (btaken)
    );

    branchUnit branchUnit0
    (
        .pc       (pipe5Reg.pc),
        .opA      (pipe5Reg.opA),
        .opB      (pipe5Reg.opB),   // I imm for jalr
        .bImm     (pipe5Reg.bImm),
        .jImm     (pipe5Reg.jImm),
        .j        (pipe5Reg.j),
        .jr       (pipe5Reg.jr),
        .btaken   (btaken),
        .target   (target),
        .redirect (redirect)
    );

    // memory request goes straight from issue, result lands in pipe 6
    dataMemWrap #(.MemWords(MemWords)) dataMemWrap0
    (
        .clk    (clk),
        .nrst   (nrst),
        .valid  (issue.valid),
        .memOp  (issue.memOp),
        .opA    (issue.opA),
        .opB    (issue.opB),
        .sImm   (issue.sImm),
        .memOut (memOut)
    );

    assign exeOut.valid    = pipe5Reg.valid;
    assign exeOut.we       = pipe5Reg.we & pipe5Reg.valid;
    assign exeOut.rd       = pipe5Reg.rd;
    assign exeOut.aluRes   = aluRes;
    assign exeOut.redirect = redirect & pipe5Reg.valid;   // no redirect from a bubble
    assign exeOut.target   = target;

endmodule

`default_nettype wire

//--- tests/exeStage_assertions.sv
`timescale 1ns/1ns
`default_nettype none

module exeStageAssertions
(
    input logic                clk,
    input logic                nrst,
    input exePkg::issueBundleT issue,
    input exePkg::exeResultT   exeOut,
    input exePkg::memResultT   memOut
);
    import exePkg::*;

    // pipe 5 strobe one clock behind the issue strobe
    exeValidLatency: assert property (@(posedge clk) disable iff (!nrst)
        $past(issue.valid) |-> exeOut.valid)
        else $error("exeOut.valid missing one cycle after issue.valid");

    memValidLatency: assert property (@(posedge clk) disable iff (!nrst)
        $past(issue.valid && (issue.memOp != memNone), 2) |-> memOut.valid)
        else $error("memOut.valid missing two cycles after a memory issue");

    // a bubble or a plain ALU op never redirects fetch
    redirectNeedsValid: assert property (@(posedge clk) disable iff (!nrst)
        exeOut.redirect |-> exeOut.valid &&
            ($past(issue.j) || $past(issue.jr) || $past(issue.btype)))
        else $error("exeOut.redirect high without a valid branch or jump");

endmodule

bind exeStage exeStageAssertions exeStageAssertions0
(
    .clk    (clk),
    .nrst   (nrst),
    .issue  (issue),
    .exeOut (exeOut),
    .memOut (memOut)
);

`default_nettype wire

//--- tests/exeStageTb.sv
`timescale 1ns/1ns
`default_nettype none

module exeStageTb;
    import exePkg::*;

    // one row of stimulus with its expected pipe 5 and pipe 6 values
    typedef struct packed
    {
        issueBundleT issue;
        logic [31:0] aluRes;
        logic [31:0] target;
        logic        redirect;
        logic [31:0] memData;
        logic        memMisaligned;
    } stimT;

    logic        clk;
    logic        nrst;
    issueBundleT issue;
    exeResultT   exeOut;
    memResultT   memOut;

    stimT  stimTable[$];
    string stimNames[$];
    stimT  exePending[$];   // strobes waiting for pipe 5
    string exeNames[$];
    int    exeDue[$];       // edge count at which pipe 5 must show it
    stimT  memPending[$];   // memory ops waiting for pipe 6
    string memNames[$];
    int    memDue[$];
    int    edgeCount = 0;   // rising clock edges so far
    int    seed;

    exeStage #(.MemWords(64)) dut0
    (
        .clk    (clk),
        .nrst   (nrst),
        .issue  (issue),
        .exeOut (exeOut),
        .memOut (memOut)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk)
        edgeCount <= edgeCount + 1;

    task automatic stopRun();
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic checkValue(string name, logic [31:0] expected, logic [31:0] actual);
        if (actual !== expected)
        begin
            $display("Mismatch %s expected %h actual %h", name, expected, actual);
            stopRun();
        end
    endtask

    // RV32I integer rules, shifts use the low five bits of b
    function automatic logic [31:0] aluModel(aluOpT op, logic [31:0] a, logic [31:0] b);
        logic [4:0]  sh;
        logic [31:0] fill;
        sh   = b[4:0];
        fill = a[31] ? ~(32'hffff_ffff >> sh) : 32'd0;   // sign bits shifted in by sra
        case (op)
            aluAdd:  return a + b;
            aluSub:  return a + ~b + 32'd1;
            aluSll:  return a << sh;
            aluSlt:  return (a[31] != b[31]) ? {31'd0, a[31]} : {31'd0, a < b};
            aluSltu: return {31'd0, a < b};
            aluXor:  return a ^ b;
            aluSrl:  return a >> sh;
            aluSra:  return (a >> sh) | fill;
            aluOr:   return a | b;
            aluAnd:  return a & b;
            default: return 32'd0;
        endcase
    endfunction

    // plain ALU instruction, falls through to pc + 4
    function automatic stimT baseStim(aluOpT op, logic [31:0] a, logic [31:0] b,
                                      logic [31:0] pc);
        stimT s;
        s = '0;
        s.issue.valid = 1'b1;
        s.issue.we    = 1'b1;
        s.issue.rd    = 5'd1;
        s.issue.aluOp = op;
        s.issue.opA   = a;
        s.issue.opB   = b;
        s.issue.pc    = pc;
        s.aluRes      = aluModel(op, a, b);
        s.target      = pc + 32'd4;
        return s;
    endfunction

    task automatic pushEntry(stimT s, string name);
        s.issue.rd = 5'(stimTable.size() + 1);   // a different rd per row
        stimTable.push_back(s);
        stimNames.push_back(name);
    endtask

    task automatic addAlu(string name, aluOpT op, logic [31:0] a, logic [31:0] b,
                          logic [31:0] res);
        stimT s;
        s = baseStim(op, a, b, 32'h100);
        s.aluRes = res;   // worked out by hand
        pushEntry(s, name);
    endtask

    task automatic addBranch(string name, aluOpT op, logic bneq, logic [31:0] a,
                             logic [31:0] b, logic taken);
        stimT s;
        s = baseStim(op, a, b, 32'h200);
        s.issue.we    = 1'b0;
        s.issue.btype = 1'b1;
        s.issue.bneq  = bneq;
        s.issue.bImm  = 32'h40;
        s.redirect    = taken;
        s.target      = taken ? 32'h240 : 32'h204;
        pushEntry(s, name);
    endtask

    // loads use a + b, stores use a + off and write b
    task automatic addMem(string name, memOpT op, logic [31:0] a, logic [31:0] b,
                          logic [31:0] off, logic [31:0] data, logic mis);
        stimT s;
        s = baseStim(aluAdd, a, b, 32'h0);
        s.issue.memOp = op;
        s.issue.sImm  = off;
        s.memData     = data;
        s.memMisaligned = mis;
        pushEntry(s, name);
    endtask

    task automatic buildTable();
        stimT s;
        addAlu("add", aluAdd, 32'h0000_1234, 32'h0000_0f0f, 32'h0000_2143);
        addAlu("sub", aluSub, 32'h10, 32'h20, 32'hffff_fff0);
        addAlu("sll", aluSll, 32'h1, 32'h3f, 32'h8000_0000);   // only 5 bits of shift
        addAlu("slt", aluSlt, 32'hffff_ffff, 32'h1, 32'h1);
        addAlu("sltu", aluSltu, 32'hffff_ffff, 32'h1, 32'h0);
        addAlu("xor", aluXor, 32'hf0f0_f0f0, 32'hff00_ff00, 32'h0ff0_0ff0);
        addAlu("srl", aluSrl, 32'h8000_0000, 32'h4, 32'h0800_0000);
        addAlu("sra", aluSra, 32'h8000_0000, 32'h4, 32'hf800_0000);
        addAlu("or", aluOr, 32'h0f00, 32'h00f0, 32'h0ff0);
        addAlu("and", aluAnd, 32'hff00_ff00, 32'h0ff0_0ff0, 32'h0f00_0f00);
        addBranch("beqTaken", aluSub, 1'b0, 32'h5, 32'h5, 1'b1);
        addBranch("beqNot", aluSub, 1'b0, 32'h5, 32'h6, 1'b0);
        addBranch("bneTaken", aluSub, 1'b1, 32'h5, 32'h6, 1'b1);
        addBranch("bneNot", aluSub, 1'b1, 32'h5, 32'h5, 1'b0);
        addBranch("bltTaken", aluSlt, 1'b0, 32'hffff_fffe, 32'h3, 1'b1);
        addBranch("bltNot", aluSlt, 1'b0, 32'h3, 32'hffff_fffe, 1'b0);
        addBranch("bgeTaken", aluSlt, 1'b1, 32'h3, 32'hffff_fffe, 1'b1);
        addBranch("bgeNot", aluSlt, 1'b1, 32'hffff_fffe, 32'h3, 1'b0);
        addBranch("bltuTaken", aluSltu, 1'b0, 32'h3, 32'hffff_fffe, 1'b1);
        addBranch("bltuNot", aluSltu, 1'b0, 32'hffff_fffe, 32'h3, 1'b0);
        addBranch("bgeuTaken", aluSltu, 1'b1, 32'hffff_fffe, 32'h3, 1'b1);
        addBranch("bgeuNot", aluSltu, 1'b1, 32'h3, 32'hffff_fffe, 1'b0);
        s = baseStim(aluAdd, 32'h0, 32'h0, 32'h300);
        s.issue.j    = 1'b1;
        s.issue.jImm = 32'h800;
        s.target     = 32'hb00;
        s.redirect   = 1'b1;
        pushEntry(s, "jal");
        s = baseStim(aluAdd, 32'h1001, 32'h20, 32'h300);
        s.issue.jr = 1'b1;
        s.target   = 32'h1020;   // bit 0 of the sum cleared
        s.redirect = 1'b1;
        pushEntry(s, "jalr");
        s = baseStim(aluSub, 32'h7, 32'h7, 32'h300);
        s.issue.bImm = 32'h40;   // equal operands but btype low
        pushEntry(s, "noBranch");
        addMem("sw", memSw, 32'h40, 32'h8765_4321, 32'h0, 32'h0, 1'b0);
        addMem("sh", memSh, 32'h40, 32'h0000_f00d, 32'h6, 32'h0, 1'b0);
        addMem("sb", memSb, 32'h40, 32'h0000_00a5, 32'h9, 32'h0, 1'b0);
        addMem("lw", memLw, 32'h40, 32'h0, 32'h0, 32'h8765_4321, 1'b0);
        addMem("lhUpper", memLh, 32'h40, 32'h2, 32'h0, 32'hffff_8765, 1'b0);
        addMem("lhuUpper", memLhu, 32'h40, 32'h2, 32'h0, 32'h0000_8765, 1'b0);
        addMem("lbTop", memLb, 32'h40, 32'h3, 32'h0, 32'hffff_ff87, 1'b0);
        addMem("lbuLow", memLbu, 32'h40, 32'h0, 32'h0, 32'h0000_0021, 1'b0);
        addMem("lhStored", memLh, 32'h40, 32'h6, 32'h0, 32'hffff_f00d, 1'b0);
        addMem("lhuStored", memLhu, 32'h40, 32'h6, 32'h0, 32'h0000_f00d, 1'b0);
        addMem("lbStored", memLb, 32'h40, 32'h9, 32'h0, 32'hffff_ffa5, 1'b0);
        addMem("lbuStored", memLbu, 32'h40, 32'h9, 32'h0, 32'h0000_00a5, 1'b0);
        addMem("lhOdd", memLh, 32'h40, 32'h1, 32'h0, 32'h0, 1'b1);
        addMem("lwOffset2", memLw, 32'h40, 32'h2, 32'h0, 32'h0, 1'b1);
        addMem("swMisaligned", memSw, 32'h40, 32'hdead_beef, 32'h2, 32'h0, 1'b1);
        addMem("lwAfterBadSw", memLw, 32'h40, 32'h0, 32'h0, 32'h8765_4321, 1'b0);
    endtask

    // strobe goes out on edge edgeCount + 1
    task automatic applyEntry(stimT s, string name);
        @(posedge clk);
        issue <= s.issue;
        exePending.push_back(s);
        exeNames.push_back(name);
        exeDue.push_back(edgeCount + 2);
        if (s.issue.memOp != memNone)
        begin
            memPending.push_back(s);
            memNames.push_back(name);
            memDue.push_back(edgeCount + 3);
        end
    endtask

    task automatic waitDrain(string what);
        int cycles;
        cycles = 0;
        while ((exePending.size() != 0) || (memPending.size() != 0))
        begin
            @(negedge clk);
            cycles++;
            if (cycles > 50)
            begin
                $display("timeout while waiting for the results of the %s", what);
                stopRun();
            end
        end
    endtask

    // results come back in issue order, checked mid cycle
    always @(negedge clk)
    begin : exeMonitor
        stimT  e;
        string n;
        int    due;
        if (nrst && exeOut.valid)
        begin
            if (exePending.size() == 0)
            begin
                $display("exeOut.valid went high with no instruction outstanding");
                stopRun();
            end
            else
            begin
                e   = exePending.pop_front();
                n   = exeNames.pop_front();
                due = exeDue.pop_front();
                if (due != edgeCount)
                begin
                    $display("%s reached pipe 5 at edge %0d instead of edge %0d",
                             n, edgeCount, due);
                    stopRun();
                end
                checkValue({n, " aluRes"}, e.aluRes, exeOut.aluRes);
                checkValue({n, " target"}, e.target, exeOut.target);
                checkValue({n, " redirect"}, 32'(e.redirect), 32'(exeOut.redirect));
                checkValue({n, " we"}, 32'(e.issue.we), 32'(exeOut.we));
                checkValue({n, " rd"}, 32'(e.issue.rd), 32'(exeOut.rd));
            end
        end
        else if ((exeDue.size() != 0) && (exeDue[0] <= edgeCount))
        begin
            $display("exeOut.valid did not come one cycle after the strobe of %s",
                     exeNames[0]);
            stopRun();
        end
    end

    always @(negedge clk)
    begin : memMonitor
        stimT  e;
        string n;
        int    due;
        if (nrst && memOut.valid)
        begin
            if (memPending.size() == 0)
            begin
                $display("memOut.valid went high with no memory access outstanding");
                stopRun();
            end
            else
            begin
                e   = memPending.pop_front();
                n   = memNames.pop_front();
                due = memDue.pop_front();
                if (due != edgeCount)
                begin
                    $display("%s reached pipe 6 at edge %0d instead of edge %0d",
                             n, edgeCount, due);
                    stopRun();
                end
                checkValue({n, " data"}, e.memData, memOut.data);
                checkValue({n, " misaligned"}, 32'(e.memMisaligned),
                           32'(memOut.addrMisaligned));
            end
        end
        else if ((memDue.size() != 0) && (memDue[0] <= edgeCount))
        begin
            $display("memOut.valid did not come two cycles after the strobe of %s",
                     memNames[0]);
            stopRun();
        end
    end

    initial
    begin
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] r;
        stimT        s;
        seed  = 32'h741d;
        nrst  = 1'b0;
        issue = '0;
        buildTable();
        repeat (2) @(posedge clk);
        nrst <= 1'b1;
        @(negedge clk);
        checkValue("reset exeOut.valid", 32'd0, 32'(exeOut.valid));
        checkValue("reset exeOut.we", 32'd0, 32'(exeOut.we));
        checkValue("reset exeOut.redirect", 32'd0, 32'(exeOut.redirect));
        checkValue("reset memOut.valid", 32'd0, 32'(memOut.valid));

        // whole table back to back, one strobe per cycle
        foreach (stimTable[i])
            applyEntry(stimTable[i], stimNames[i]);
        @(posedge clk);
        issue <= '0;
        waitDrain("stimulus table");

        for (int i = 0; i < 20; i++)
        begin
            a = $random(seed);
            b = $random(seed);
            r = $random(seed);
            s = baseStim(aluOpT'(4'(r % 32'd10)), a, b, 32'h400);
            s.issue.rd = r[8:4];
            applyEntry(s, $sformatf("random%0d", i));
        end
        @(posedge clk);
        issue <= '0;
        waitDrain("random ALU operations");

        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
verilog/exePkg.sv
verilog/exeAlu.sv
verilog/branchUnit.sv
verilog/dataMemWrap.sv
verilog/exeStage.sv
tests/exeStage_assertions.sv
tests/exeStageTb.sv

//--- Makefile
TOP = exeStageTb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f verilog.f
	out=$$(./obj_dir/V$(TOP) 2>&1); echo "$$out"; echo "$$out" | grep -q "^TEST OK$$"

clean:
	rm -rf obj_dir
